//--- tb.f
hunter_cfg_pkg.sv
hunter_frame_pkg.sv
cmd_decode.sv
adc_capture.sv
frame_ram.sv
com_send.sv
test_hunter.sv
tb_clock.sv
tb_test_hunter.sv

//--- Bender.yml
package:
  name: test_hunter

sources:
  - hunter_cfg_pkg.sv
  - hunter_frame_pkg.sv
  - cmd_decode.sv
  - adc_capture.sv
  - frame_ram.sv
  - com_send.sv
  - test_hunter.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_test_hunter.sv

//--- tb_test_hunter.sv
`timescale 1ns/1ps

module tb_test_hunter import hunter_cfg_pkg::*; import hunter_frame_pkg::*; ();

    localparam int ADDR_W   = 12;
    localparam int SAMPLE_W = 16;
    localparam int TIMEOUT  = 500;

    logic                clk;
    logic                rst_n;
    cmd_word_u           cmd_data;
    logic                cmd_valid;
    logic                cmd_ready;
    logic [SAMPLE_W-1:0] sample_data;
    logic [CHAN_W-1:0]   sample_chan;
    logic                sample_valid;
    logic                sample_ready;
    logic [7:0]          tx_data;
    logic                tx_valid;
    logic                tx_ready;
    logic                tx_last;

    logic [31:0] lfsr;
    logic [7:0]  rx_bytes [$];
    logic [7:0]  exp_bytes [$];
    // expected status word tracked across converts
    stat_t       exp_stat;

    tb_clock #(
        .PERIOD     (4),
        .RST_CYCLES (5)
    ) clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    test_hunter #(
        .ADDR_W   (ADDR_W),
        .SAMPLE_W (SAMPLE_W)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_data     (cmd_data),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .sample_data  (sample_data),
        .sample_chan  (sample_chan),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_last      (tx_last)
    );

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s did not happen in time", what);
        stop_run();
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("** Error %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_stat(input string name, input stat_t exp, input stat_t act);
        if (act !== exp) begin
            $display("** Error %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic cmd_word_u make_conf(input logic [3:0] bt, input logic [7:0] mask);
        cmd_word_u w;
        w.conf.op        = OP_CONF;
        w.conf.btype     = bt;
        w.conf.chan_mask = mask;
        w.conf.rsvd      = '0;
        return w;
    endfunction

    function automatic cmd_word_u make_job(input hunter_op_e op, input logic [3:0] bt,
                                           input logic [DLEN_W-1:0] n, input addr_t a);
        cmd_word_u w;
        w.job.op        = op;
        w.job.btype     = bt;
        w.job.dlen      = n;
        w.job.addr_init = a;
        return w;
    endfunction

    task automatic send_cmd(input cmd_word_u w);
        int t;
        @(negedge clk);
        cmd_data  = w;
        cmd_valid = 1'b1;
        t = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) timeout_fail("cmd_ready");
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic push_sample(input logic [SAMPLE_W-1:0] d, input logic [CHAN_W-1:0] c);
        int t;
        @(negedge clk);
        sample_data  = d;
        sample_chan  = c;
        sample_valid = 1'b1;
        t = 0;
        while (!sample_ready) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) timeout_fail("sample_ready");
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    // takes bytes until tx_last which must sit on byte n-1
    task automatic collect_frame(input string name, input int n, input logic stalls);
        int          t;
        logic [31:0] rb;
        logic        done;
        rx_bytes.delete();
        t    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            rb       = stalls ? next_bits(1) : 32'd1;
            tx_ready = rb[0];
            if (tx_valid && tx_ready) begin
                rx_bytes.push_back(tx_data);
                check_flag($sformatf("%s tx_last at byte %0d", name, rx_bytes.size() - 1),
                           rx_bytes.size() == n, tx_last);
                done = tx_last;
                t    = 0;
            end else begin
                t++;
                if (t > TIMEOUT) timeout_fail("frame byte");
            end
        end
        @(negedge clk);
        tx_ready = 1'b0;
    endtask

    task automatic compare_frame(input string name);
        for (int i = 0; i < exp_bytes.size(); i++) begin
            check_byte($sformatf("%s byte %0d", name, i), exp_bytes[i], rx_bytes[i]);
        end
    endtask

    task automatic start_convert(input logic [DLEN_W-1:0] n, input addr_t a);
        send_cmd(make_job(OP_CONV, 4'h0, n, a));
        exp_stat.frames_done = exp_stat.frames_done + 8'd1;
        exp_stat.last_dlen   = n;
        exp_stat.addr_init   = a;
    endtask

    // full mask assumed so every sample lands in ram low byte first
    task automatic feed_samples(input int n);
        logic [SAMPLE_W-1:0] d;
        for (int i = 0; i < n; i++) begin
            d = SAMPLE_W'(next_bits(SAMPLE_W));
            push_sample(d, CHAN_W'(next_bits(CHAN_W)));
            for (int b = 0; b < SAMPLE_W / 8; b++) begin
                exp_bytes.push_back(d[8*b +: 8]);
            end
        end
    endtask

    task automatic read_status(input string name);
        stat_t got;
        send_cmd(make_job(OP_STAT, 4'h0, '0, '0));
        collect_frame(name, 6, 1'b0);
        check_byte({name, " header"}, 8'hF0, rx_bytes[0]);
        check_byte({name, " length"}, 8'd4, rx_bytes[1]);
        got = {rx_bytes[2], rx_bytes[3], rx_bytes[4], rx_bytes[5]};
        check_stat(name, exp_stat, got);
    endtask

    task automatic test_reset();
        int t;
        t = 0;
        @(posedge clk);
        while (!rst_n) begin
            check_flag("reset cmd_ready", 1'b0, cmd_ready);
            check_flag("reset sample_ready", 1'b0, sample_ready);
            check_flag("reset tx_valid", 1'b0, tx_valid);
            @(posedge clk);
            t++;
            if (t > TIMEOUT) timeout_fail("reset release");
        end
        @(negedge clk);
        check_flag("reset cmd_ready rise", 1'b1, cmd_ready);
        repeat (6) begin
            @(negedge clk);
            check_flag("idle sample_ready", 1'b0, sample_ready);
            check_flag("idle tx_valid", 1'b0, tx_valid);
        end
    endtask

    task automatic test_status_frames();
        send_cmd(make_conf(4'h1, 8'hFF));
        start_convert(12'd2, 12'h200);
        feed_samples(2);
        start_convert(12'd3, 12'h300);
        feed_samples(3);
        read_status("status_frames");
    endtask

    task automatic test_capture_send(input string name, input logic stalls);
        logic [3:0]        bt;
        logic [DLEN_W-1:0] len;
        bt  = 4'h3;
        len = 12'd8;
        exp_bytes.delete();
        exp_bytes.push_back({bt, len[11:8]});
        exp_bytes.push_back(len[7:0]);
        send_cmd(make_conf(bt, 8'hFF));
        start_convert(12'd4, 12'h010);
        feed_samples(4);
        // header takes the configured btype and not the one in the send word
        send_cmd(make_job(OP_SEND, 4'h0, len, 12'h010));
        collect_frame(name, exp_bytes.size(), stalls);
        compare_frame(name);
    endtask

    task automatic test_channel_mask();
        logic [SAMPLE_W-1:0] d;
        logic [CHAN_W-1:0]   c;
        logic [7:0]          mask;
        mask = 8'h05;
        exp_bytes.delete();
        exp_bytes.push_back(8'h50);
        exp_bytes.push_back(8'd6);
        send_cmd(make_conf(4'h5, mask));
        // channels 0 to 7 then 0 again so three samples are kept
        start_convert(12'd3, 12'h100);
        for (int i = 0; i < 9; i++) begin
            d = SAMPLE_W'(next_bits(SAMPLE_W));
            c = CHAN_W'(i % 8);
            push_sample(d, c);
            if (mask[c]) begin
                exp_bytes.push_back(d[7:0]);
                exp_bytes.push_back(d[15:8]);
            end
        end
        send_cmd(make_job(OP_SEND, 4'h0, 12'd6, 12'h100));
        collect_frame("channel_mask", exp_bytes.size(), 1'b0);
        compare_frame("channel_mask");
    endtask

    task automatic test_unknown_opcode();
        cmd_word_u w;
        w = 32'h9F12_3456;
        send_cmd(w);
        read_status("unknown_opcode");
    endtask

    initial begin
        cmd_data     = '0;
        cmd_valid    = 1'b0;
        sample_data  = '0;
        sample_chan  = '0;
        sample_valid = 1'b0;
        tx_ready     = 1'b0;
        lfsr         = 32'h89c5_3b38;
        exp_stat     = '0;

        test_reset();
        test_status_frames();
        test_capture_send("capture_send", 1'b0);
        test_channel_mask();
        test_capture_send("send_stalls", 1'b1);
        test_unknown_opcode();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a falling edge, away from the flops
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- test_hunter.sv
`timescale 1ns/1ps

module test_hunter import hunter_cfg_pkg::*; import hunter_frame_pkg::*; #(
    parameter int ADDR_W   = 12,
    parameter int SAMPLE_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cmd_word_u           cmd_data,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic [SAMPLE_W-1:0] sample_data,
    input  logic [CHAN_W-1:0]   sample_chan,
    input  logic                sample_valid,
    output logic                sample_ready,
    output logic [7:0]          tx_data,
    output logic                tx_valid,
    input  logic                tx_ready,
    output logic                tx_last
);

    // decode to capture
    logic              cap_start;
    logic              cap_done;
    logic [DLEN_W-1:0] cap_count;
    addr_t             cap_addr;
    logic [7:0]        chan_mask;

    // decode to sender
    logic              tx_start;
    logic              tx_stat;
    logic [3:0]        tx_btype;
    logic [DLEN_W-1:0] tx_dlen;
    addr_t             tx_addr;
    stat_t             stat_word;
    logic              tx_done;

    // frame ram ports
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [7:0]        wr_data;
    logic [ADDR_W-1:0] rd_addr;
    logic [7:0]        rd_data;

    cmd_decode
    cmd_decode_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_data  (cmd_data),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cap_start (cap_start),
        .cap_count (cap_count),
        .cap_addr  (cap_addr),
        .chan_mask (chan_mask),
        .cap_done  (cap_done),
        .tx_start  (tx_start),
        .tx_stat   (tx_stat),
        .tx_btype  (tx_btype),
        .tx_dlen   (tx_dlen),
        .tx_addr   (tx_addr),
        .stat_word (stat_word),
        .tx_done   (tx_done)
    );

    adc_capture #(
        .ADDR_W   (ADDR_W),
        .SAMPLE_W (SAMPLE_W)
    ) adc_capture_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cap_start    (cap_start),
        .cap_count    (cap_count),
        .cap_addr     (cap_addr),
        .chan_mask    (chan_mask),
        .sample_data  (sample_data),
        .sample_chan  (sample_chan),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .cap_done     (cap_done),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    frame_ram #(
        .ADDR_W (ADDR_W)
    ) frame_ram_dut (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    com_send #(
        .ADDR_W (ADDR_W)
    ) com_send_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_start  (tx_start),
        .tx_stat   (tx_stat),
        .tx_btype  (tx_btype),
        .tx_dlen   (tx_dlen),
        .tx_addr   (tx_addr),
        .stat_word (stat_word),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_last   (tx_last),
        .tx_done   (tx_done)
    );

endmodule

//--- com_send.sv
`timescale 1ns/1ps

module com_send import hunter_cfg_pkg::*; import hunter_frame_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tx_start,
    input  logic              tx_stat,
    input  logic [3:0]        tx_btype,
    input  logic [DLEN_W-1:0] tx_dlen,
    input  logic [ADDR_W-1:0] tx_addr,
    input  stat_t             stat_word,
    output logic [ADDR_W-1:0] rd_addr,
    input  logic [7:0]        rd_data,
    output logic [7:0]        tx_data,
    output logic              tx_valid,
    input  logic              tx_ready,
    output logic              tx_last,
    output logic              tx_done
);

    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_HDR  = 2'd1;
    localparam logic [1:0] PH_LEN  = 2'd2;
    localparam logic [1:0] PH_PAY  = 2'd3;

    logic [1:0]        phase;
    logic [DLEN_W-1:0] cnt;
    logic [DLEN_W-1:0] len_q;
    logic [3:0]        btype_q;
    logic              stat_q;
    logic [ADDR_W-1:0] ptr;
    logic [1:0]        sidx;
    logic              hs;
    logic              pay_hs;

    assign tx_valid = (phase != PH_IDLE);
    assign hs       = tx_valid && tx_ready;
    assign pay_hs   = hs && phase == PH_PAY;
    // cnt 4..1 picks status bytes 3..0
    assign sidx     = cnt[1:0] - 2'd1;
    assign tx_last  = (phase == PH_LEN && cnt == '0) ||
                      (phase == PH_PAY && cnt == DLEN_W'(1));

    // address moves with the handshake so the next byte is ready right after
    assign rd_addr = pay_hs ? ptr + 1'b1 : ptr;

    always_comb begin
        case (phase)
            PH_HDR:  tx_data = {btype_q, len_q[11:8]};
            PH_LEN:  tx_data = len_q[7:0];
            PH_PAY:  tx_data = stat_q ? stat_word[8*sidx +: 8] : rd_data;
            default: tx_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= PH_IDLE;
            cnt     <= '0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (tx_start) begin
                        phase <= PH_HDR;
                        cnt   <= tx_stat ? DLEN_W'(4) : tx_dlen;
                    end
                end
                PH_HDR: begin
                    if (hs) begin
                        phase <= PH_LEN;
                    end
                end
                PH_LEN: begin
                    if (hs) begin
                        phase   <= (cnt == '0) ? PH_IDLE : PH_PAY;
                        tx_done <= (cnt == '0);
                    end
                end
                default: begin
                    if (hs) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == DLEN_W'(1)) begin
                            phase   <= PH_IDLE;
                            tx_done <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && tx_start) begin
            stat_q  <= tx_stat;
            btype_q <= tx_stat ? BTYPE_STAT : tx_btype;
            len_q   <= tx_stat ? DLEN_W'(4) : tx_dlen;
            ptr     <= tx_addr;
        end else if (pay_hs) begin
            ptr <= ptr + 1'b1;
        end
    end

    // covers the ram-sourced payload as well as the header bytes
    assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> $stable(tx_data));

endmodule

//--- frame_ram.sv
`timescale 1ns/1ps

module frame_ram #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [7:0]        wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [7:0]        rd_data
);

    logic [7:0] mem [0:(1 << ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- adc_capture.sv
`timescale 1ns/1ps

module adc_capture import hunter_cfg_pkg::*; #(
    parameter int ADDR_W   = 12,
    parameter int SAMPLE_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cap_start,
    input  logic [DLEN_W-1:0]   cap_count,
    input  logic [ADDR_W-1:0]   cap_addr,
    input  logic [7:0]          chan_mask,
    input  logic [SAMPLE_W-1:0] sample_data,
    input  logic [CHAN_W-1:0]   sample_chan,
    input  logic                sample_valid,
    output logic                sample_ready,
    output logic                cap_done,
    output logic                wr_en,
    output logic [ADDR_W-1:0]   wr_addr,
    output logic [7:0]          wr_data
);

    localparam int NBYTES = SAMPLE_W / 8;
    localparam int BIDX_W = (NBYTES > 1) ? $clog2(NBYTES) : 1;

    logic                active;
    logic                splitting;
    logic [DLEN_W-1:0]   remaining;
    logic [BIDX_W-1:0]   byte_idx;
    logic [SAMPLE_W-1:0] sample_q;
    logic                take;

    // out-of-mask samples are still consumed, just not kept
    assign sample_ready = active && !splitting;
    assign take         = sample_valid && sample_ready && chan_mask[sample_chan];

    // little-endian, low byte first
    assign wr_en   = splitting;
    assign wr_data = sample_q[8*byte_idx +: 8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            splitting <= 1'b0;
            remaining <= '0;
            byte_idx  <= '0;
            cap_done  <= 1'b0;
        end else begin
            cap_done <= 1'b0;
            if (cap_start) begin
                // zero-length convert finishes at once
                active    <= (cap_count != '0);
                cap_done  <= (cap_count == '0);
                remaining <= cap_count;
            end else if (take) begin
                splitting <= 1'b1;
                byte_idx  <= '0;
            end else if (splitting) begin
                if (byte_idx == BIDX_W'(NBYTES - 1)) begin
                    splitting <= 1'b0;
                    remaining <= remaining - 1'b1;
                    if (remaining == DLEN_W'(1)) begin
                        active   <= 1'b0;
                        cap_done <= 1'b1;
                    end
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cap_start) begin
            wr_addr <= cap_addr;
        end else if (splitting) begin
            wr_addr <= wr_addr + 1'b1;
        end
        if (take) begin
            sample_q <= sample_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> active);

endmodule

//--- cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode import hunter_cfg_pkg::*; import hunter_frame_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  cmd_word_u         cmd_data,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    output logic              cap_start,
    output logic [DLEN_W-1:0] cap_count,
    output addr_t             cap_addr,
    output logic [7:0]        chan_mask,
    input  logic              cap_done,
    output logic              tx_start,
    output logic              tx_stat,
    output logic [3:0]        tx_btype,
    output logic [DLEN_W-1:0] tx_dlen,
    output addr_t             tx_addr,
    output stat_t             stat_word,
    input  logic              tx_done
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CAP  = 2'd1;
    localparam logic [1:0] ST_SEND = 2'd2;

    logic [1:0] state;
    logic       cmd_fire;
    hunter_op_e op;

    assign cmd_fire = cmd_valid && cmd_ready;
    // opcode sits in the same bits in both views
    assign op       = cmd_data.conf.op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            cmd_ready <= 1'b0;
            cap_start <= 1'b0;
            tx_start  <= 1'b0;
            chan_mask <= '0;
            tx_btype  <= '0;
            stat_word <= '0;
        end else begin
            cap_start <= 1'b0;
            tx_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    cmd_ready <= 1'b1;
                    if (cmd_fire) begin
                        case (op)
                            OP_CONF: begin
                                chan_mask <= cmd_data.conf.chan_mask;
                                tx_btype  <= cmd_data.conf.btype;
                            end
                            OP_CONV: begin
                                state     <= ST_CAP;
                                cmd_ready <= 1'b0;
                                cap_start <= 1'b1;
                            end
                            OP_SEND, OP_STAT: begin
                                state     <= ST_SEND;
                                cmd_ready <= 1'b0;
                                tx_start  <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                ST_CAP: begin
                    if (cap_done) begin
                        state                 <= ST_IDLE;
                        cmd_ready             <= 1'b1;
                        stat_word.frames_done <= stat_word.frames_done + 1'b1;
                        stat_word.last_dlen   <= cap_count;
                        stat_word.addr_init   <= cap_addr;
                    end
                end
                ST_SEND: begin
                    if (tx_done) begin
                        state     <= ST_IDLE;
                        cmd_ready <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // job parameters, only taken while idle
    always_ff @(posedge clk) begin
        if (cmd_fire && op == OP_CONV) begin
            cap_count <= cmd_data.job.dlen;
            cap_addr  <= cmd_data.job.addr_init;
        end
        if (cmd_fire && (op == OP_SEND || op == OP_STAT)) begin
            tx_stat <= (op == OP_STAT);
            tx_dlen <= cmd_data.job.dlen;
            tx_addr <= cmd_data.job.addr_init;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(cap_start && tx_start));

    // capture engine only reports back on a job we launched
    assert property (@(posedge clk) disable iff (!rst_n) cap_done |-> state == ST_CAP);

endmodule

//--- hunter_frame_pkg.sv
package hunter_frame_pkg;

    import hunter_cfg_pkg::*;

    // configure view
    typedef struct packed {
        hunter_op_e  op;
        logic [3:0]  btype;
        logic [7:0]  chan_mask;
        logic [15:0] rsvd;
    } cmd_conf_t;

    // convert, send and status view
    typedef struct packed {
        hunter_op_e        op;
        logic [3:0]        btype;
        logic [DLEN_W-1:0] dlen;
        addr_t             addr_init;
    } cmd_job_t;

    typedef union packed {
        cmd_conf_t conf;
        cmd_job_t  job;
    } cmd_word_u;

    // status payload, msb first on the wire
    typedef struct packed {
        logic [7:0]        frames_done;
        logic [DLEN_W-1:0] last_dlen;
        addr_t             addr_init;
    } stat_t;

endpackage

//--- hunter_cfg_pkg.sv
package hunter_cfg_pkg;

    // job length field width, samples or bytes
    localparam int DLEN_W = 12;

    // adc front end has eight channels
    localparam int CHAN_W = 3;

    // ram byte address, ram_txa / ram_rxa width
    typedef logic [11:0] addr_t;

    // host opcodes, everything else is dropped
    typedef enum logic [3:0] {
        OP_CONF = 4'h1,
        OP_CONV = 4'h2,
        OP_SEND = 4'h3,
        OP_STAT = 4'h4
    } hunter_op_e;

    // block type reserved for status frames
    localparam logic [3:0] BTYPE_STAT = 4'hF;

endpackage
